// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := video_composite_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) verification/video_cases.txt
	$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
common/video_pkg.sv
common/video_if.sv
timing/video_timing.sv
source/palette_stage.sv
source/composite_modulator.sv
source/video_composite_top.sv
verification/video_composite_assertions.sv
verification/video_composite_tb.sv

// File: common/video_if.sv
`timescale 1ns/10ps
`default_nettype none

// flags straight from the counters, same cycle
interface timing_if;
    logic sync_n;
    logic burst;
    logic active;
    logic pix_valid;

    modport source (output sync_n, burst, active, pix_valid);
    modport sink   (input  sync_n, burst, active, pix_valid);
endinterface

// palette output, one cycle behind timing_if
interface pixel_if;
    logic                sync_n;
    logic                burst;
    logic                active;
    video_pkg::rgb12_t   rgb;

    modport source (output sync_n, burst, active, rgb);
    modport sink   (input  sync_n, burst, active, rgb);
endinterface

`default_nettype wire

// File: common/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [10:0] hcount_t;
    typedef logic [10:0] vcount_t;
    typedef logic [3:0]  pal_index_t;
    typedef logic [11:0] rgb12_t;
    typedef logic [3:0]  color4_t;
    typedef logic [5:0]  level6_t;

    // half-lines of field 0, field 1 repeats them after V_FIELD1_LAST
    localparam vcount_t V_EQ1_END     = 11'd5;
    localparam vcount_t V_SYNC_FIRST  = 11'd6;
    localparam vcount_t V_SYNC_LAST   = 11'd11;
    localparam vcount_t V_EQ2_END     = 11'd17;
    localparam vcount_t V_FIELD1_LAST = 11'd524;
    localparam vcount_t V_FRAME_LAST  = 11'd1049;

    // visible half-lines, 240 lines per field
    localparam vcount_t V_ACT0_FIRST  = 11'd42;
    localparam vcount_t V_ACT0_LAST   = 11'd521;
    localparam vcount_t V_ACT1_FIRST  = 11'd568;
    localparam vcount_t V_ACT1_LAST   = 11'd1047;

    // output levels
    localparam level6_t LUMA_SYNC  = 6'd0;
    localparam level6_t LUMA_BLANK = 6'd16;
    localparam level6_t CHROMA_MID = 6'd32;
    localparam level6_t BURST_AMP  = 6'd8;

    // pulse widths in pixel clocks, measured from each half-line start
    localparam hcount_t VSYNC_PULSE_LEN = 11'd678;
    localparam hcount_t EQ_PULSE_LEN    = 11'd58;

endpackage

`default_nettype wire

// File: source/composite_modulator.sv
`timescale 1ns/10ps
`default_nettype none

module composite_modulator (
    input  wire                   clk,
    input  wire                   rst,
    pixel_if.sink                 pix,
    output video_pkg::level6_t    luma,
    output video_pkg::level6_t    chroma,
    output video_pkg::color4_t    rgb_r,
    output video_pkg::color4_t    rgb_g,
    output video_pkg::color4_t    rgb_b,
    output logic                  rgb_sync_n
);

    logic [1:0]          phase;
    video_pkg::color4_t  r, g, b;
    logic [7:0]          y_sum;
    logic signed [6:0]   y4, u, v;
    logic signed [6:0]   ofs;
    logic signed [6:0]   chroma_sum;
    video_pkg::level6_t  luma_next;

    assign r = pix.rgb[11:8];
    assign g = pix.rgb[7:4];
    assign b = pix.rgb[3:0];

    // weighted luma sum, at most 240
    assign y_sum = 8'd5 * {4'd0, r} + 8'd9 * {4'd0, g} + 8'd2 * {4'd0, b};

    assign y4 = $signed({3'b000, y_sum[7:4]});
    assign u  = $signed({3'b000, b}) - y4;
    assign v  = $signed({3'b000, r}) - y4;

    always_comb begin
        if (!pix.sync_n) begin
            luma_next = video_pkg::LUMA_SYNC;
        end else if (pix.active) begin
            luma_next = video_pkg::LUMA_BLANK + {1'b0, y_sum[7:3]};
        end else begin
            luma_next = video_pkg::LUMA_BLANK;
        end
    end

    // square-wave subcarrier, one step per phase
    always_comb begin
        ofs = '0;
        if (pix.active) begin
            case (phase)
                2'd0: ofs = u;
                2'd1: ofs = v;
                2'd2: ofs = -u;
                default: ofs = -v;
            endcase
        end else if (pix.burst) begin
            if (phase == 2'd0) begin
                ofs = $signed({1'b0, video_pkg::BURST_AMP});
            end else if (phase == 2'd2) begin
                ofs = -$signed({1'b0, video_pkg::BURST_AMP});
            end
        end
    end

    assign chroma_sum = $signed({1'b0, video_pkg::CHROMA_MID}) + ofs;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= 2'd0;
            luma       <= video_pkg::LUMA_BLANK;
            chroma     <= video_pkg::CHROMA_MID;
            rgb_r      <= '0;
            rgb_g      <= '0;
            rgb_b      <= '0;
            rgb_sync_n <= 1'b1;
        end else begin
            phase      <= phase + 2'd1;
            luma       <= luma_next;
            chroma     <= chroma_sum[5:0];
            rgb_r      <= pix.active ? r : 4'd0;
            rgb_g      <= pix.active ? g : 4'd0;
            rgb_b      <= pix.active ? b : 4'd0;
            rgb_sync_n <= pix.sync_n;
        end
    end

endmodule

`default_nettype wire

// File: source/palette_stage.sv
`timescale 1ns/10ps
`default_nettype none

module palette_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire video_pkg::pal_index_t pixel_index,
    input  wire                    pal_wr,
    input  wire video_pkg::pal_index_t pal_addr,
    input  wire video_pkg::rgb12_t pal_data,
    timing_if.sink                 tim,
    pixel_if.source                pix
);

    video_pkg::rgb12_t pal_mem [16];

    // write port, a same-cycle read still sees the old entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                pal_mem[i] <= '0;
            end
        end else if (pal_wr) begin
            pal_mem[pal_addr] <= pal_data;
        end
    end

    // lookup and flag delay share one register step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix.rgb    <= '0;
            pix.sync_n <= 1'b1;
            pix.burst  <= 1'b0;
            pix.active <= 1'b0;
        end else begin
            if (tim.pix_valid) begin
                pix.rgb <= pal_mem[pixel_index];
            end else begin
                pix.rgb <= '0;
            end
            pix.sync_n <= tim.sync_n;
            pix.burst  <= tim.burst;
            pix.active <= tim.active;
        end
    end

endmodule

`default_nettype wire

// File: source/video_composite_top.sv
`timescale 1ns/10ps
`default_nettype none

module video_composite_top #(
    parameter int H_SYNC        = 118,
    parameter int H_BACK_PORCH  = 152,
    parameter int H_ACTIVE      = 1280,
    parameter int H_FRONT_PORCH = 38,
    parameter int H_BURST_START = 132,
    parameter int H_BURST_END   = 196
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire video_pkg::pal_index_t pixel_index,
    input  wire                        pal_wr,
    input  wire video_pkg::pal_index_t pal_addr,
    input  wire video_pkg::rgb12_t     pal_data,
    output logic                       next_frame,
    output logic                       next_line,
    output logic                       next_pixel,
    output logic                       vblank_pulse,
    output logic                       current_field,
    output video_pkg::level6_t         luma,
    output video_pkg::level6_t         chroma,
    output video_pkg::color4_t         rgb_r,
    output video_pkg::color4_t         rgb_g,
    output video_pkg::color4_t         rgb_b,
    output logic                       rgb_sync_n
);

    timing_if tim_bus ();
    pixel_if  pix_bus ();

    video_timing #(
        .H_SYNC        (H_SYNC),
        .H_BACK_PORCH  (H_BACK_PORCH),
        .H_ACTIVE      (H_ACTIVE),
        .H_FRONT_PORCH (H_FRONT_PORCH),
        .H_BURST_START (H_BURST_START),
        .H_BURST_END   (H_BURST_END)
    ) u_timing (
        .clk           (clk),
        .rst           (rst),
        .tim           (tim_bus.source),
        .next_frame    (next_frame),
        .next_line     (next_line),
        .next_pixel    (next_pixel),
        .vblank_pulse  (vblank_pulse),
        .current_field (current_field)
    );

    palette_stage u_palette (
        .clk         (clk),
        .rst         (rst),
        .pixel_index (pixel_index),
        .pal_wr      (pal_wr),
        .pal_addr    (pal_addr),
        .pal_data    (pal_data),
        .tim         (tim_bus.sink),
        .pix         (pix_bus.source)
    );

    composite_modulator u_modulator (
        .clk        (clk),
        .rst        (rst),
        .pix        (pix_bus.sink),
        .luma       (luma),
        .chroma     (chroma),
        .rgb_r      (rgb_r),
        .rgb_g      (rgb_g),
        .rgb_b      (rgb_b),
        .rgb_sync_n (rgb_sync_n)
    );

endmodule

`default_nettype wire

// File: timing/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing #(
    parameter int H_SYNC        = 118,
    parameter int H_BACK_PORCH  = 152,
    parameter int H_ACTIVE      = 1280,
    parameter int H_FRONT_PORCH = 38,
    parameter int H_BURST_START = 132,
    parameter int H_BURST_END   = 196
) (
    input  wire       clk,
    input  wire       rst,
    timing_if.source  tim,
    output logic      next_frame,
    output logic      next_line,
    output logic      next_pixel,
    output logic      vblank_pulse,
    output logic      current_field
);

    localparam int H_TOTAL = H_SYNC + H_BACK_PORCH + H_ACTIVE + H_FRONT_PORCH;

    localparam video_pkg::hcount_t H_LAST      = video_pkg::hcount_t'(H_TOTAL - 1);
    localparam video_pkg::hcount_t H_HALF      = video_pkg::hcount_t'(H_TOTAL / 2);
    localparam video_pkg::hcount_t H_SYNC_LEN  = video_pkg::hcount_t'(H_SYNC);
    localparam video_pkg::hcount_t H_ACT_FIRST = video_pkg::hcount_t'(H_SYNC + H_BACK_PORCH);
    localparam video_pkg::hcount_t H_ACT_END   =
        video_pkg::hcount_t'(H_SYNC + H_BACK_PORCH + H_ACTIVE);
    localparam video_pkg::hcount_t H_BST_FIRST = video_pkg::hcount_t'(H_BURST_START);
    localparam video_pkg::hcount_t H_BST_END   = video_pkg::hcount_t'(H_BURST_END);

    video_pkg::hcount_t hcnt;
    video_pkg::vcount_t vcnt;
    video_pkg::vcount_t vrel;
    logic               field;
    logic               frame_armed;

    logic h_last;
    logic h_half_last;
    logic v_last;
    logic h_hsync, h_vsync, h_eq;
    logic h_active, h_burst;
    logic v_sync, v_eq, v_active;
    logic arm_frame;

    assign h_last      = (hcnt == H_LAST);
    assign h_half_last = (hcnt == H_HALF - 11'd1) || h_last;
    assign v_last      = (vcnt == video_pkg::V_FRAME_LAST);

    // vsync and eq pulses repeat at the half-line
    assign h_hsync = (hcnt < H_SYNC_LEN);
    assign h_vsync = (hcnt < video_pkg::VSYNC_PULSE_LEN) ||
                     (hcnt >= H_HALF && hcnt < H_HALF + video_pkg::VSYNC_PULSE_LEN);
    assign h_eq    = (hcnt < video_pkg::EQ_PULSE_LEN) ||
                     (hcnt >= H_HALF && hcnt < H_HALF + video_pkg::EQ_PULSE_LEN);

    assign h_active = (hcnt >= H_ACT_FIRST) && (hcnt < H_ACT_END);
    assign h_burst  = (hcnt >= H_BST_FIRST) && (hcnt < H_BST_END);

    // half-line number relative to the start of the current field
    always_comb begin
        if (vcnt > video_pkg::V_FIELD1_LAST) begin
            vrel = vcnt - (video_pkg::V_FIELD1_LAST + 11'd1);
        end else begin
            vrel = vcnt;
        end
    end

    assign v_sync   = (vrel >= video_pkg::V_SYNC_FIRST) && (vrel <= video_pkg::V_SYNC_LAST);
    assign v_eq     = (vrel <= video_pkg::V_EQ1_END) ||
                      (vrel > video_pkg::V_SYNC_LAST && vrel <= video_pkg::V_EQ2_END);
    assign v_active =
        (vcnt >= video_pkg::V_ACT0_FIRST && vcnt <= video_pkg::V_ACT0_LAST) ||
        (vcnt >= video_pkg::V_ACT1_FIRST && vcnt <= video_pkg::V_ACT1_LAST);

    // half-line class picks the sync pulse shape
    always_comb begin
        if (v_sync) begin
            tim.sync_n = ~h_vsync;
        end else if (v_eq) begin
            tim.sync_n = ~h_eq;
        end else begin
            tim.sync_n = ~h_hsync;
        end
    end

    assign tim.burst     = v_active && h_burst;
    assign tim.active    = v_active && h_active;
    assign tim.pix_valid = h_active;

    assign next_line    = (hcnt == H_ACT_FIRST - 11'd1);
    assign next_pixel   = h_active;
    assign vblank_pulse = h_half_last &&
        (vcnt == video_pkg::V_FIELD1_LAST || vcnt == video_pkg::V_FRAME_LAST);
    assign next_frame   = frame_armed && next_line;

    // end of the half-line just before the first visible one
    assign arm_frame = h_last &&
        (vcnt == video_pkg::V_ACT0_FIRST - 11'd1 || vcnt == video_pkg::V_ACT1_FIRST - 11'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            hcnt <= h_last ? '0 : hcnt + 11'd1;
            if (h_half_last) begin
                vcnt <= v_last ? '0 : vcnt + 11'd1;
            end
        end
    end

    // half-lines 0 to 524 belong to field 1 even right after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            field <= 1'b1;
        end else if (h_half_last && v_last) begin
            field <= 1'b1;
        end else if (h_half_last && vcnt == video_pkg::V_FIELD1_LAST) begin
            field <= 1'b0;
        end
    end

    // armed for one line and fires on that line's next_line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_armed   <= 1'b0;
            current_field <= 1'b0;
        end else if (arm_frame) begin
            frame_armed   <= 1'b1;
            current_field <= field;
        end else if (next_line) begin
            frame_armed   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verification/video_cases.txt
// columns: palette index, rgb (red, green, blue nibbles), expected active luma
// all values in hex, one palette entry per line, the first entry must be black
0 000 10
1 fff 2e
2 f00 19
3 0f0 20
4 00f 13
5 888 20
6 3a5 1e
7 c47 1d
9 1e9 22
c 7d2 23

// File: verification/video_composite_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module video_composite_assertions (
    input wire       clk,
    input wire       rst,
    input wire       next_frame,
    input wire       next_line,
    input wire       vblank_pulse,
    input wire [5:0] luma,
    input wire [3:0] rgb_r,
    input wire [3:0] rgb_g,
    input wire [3:0] rgb_b,
    input wire       rgb_sync_n
);

    int error_count = 0;

    // a field always starts on a line start
    frame_on_line: assert property (@(posedge clk) disable iff (rst)
        next_frame |-> next_line)
        else begin
            $error("next_frame high without next_line");
            error_count++;
        end

    // sync level is the only zero luma
    luma_zero_is_sync: assert property (@(posedge clk) disable iff (rst)
        (luma == 6'd0) == !rgb_sync_n)
        else begin
            $error("luma zero does not match the sync pulse");
            error_count++;
        end

    vblank_single: assert property (@(posedge clk) disable iff (rst)
        vblank_pulse |=> !vblank_pulse)
        else begin
            $error("vblank_pulse lasted two cycles");
            error_count++;
        end

    rgb_outside_sync: assert property (@(posedge clk) disable iff (rst)
        (rgb_r != 4'd0 || rgb_g != 4'd0 || rgb_b != 4'd0) |-> rgb_sync_n)
        else begin
            $error("rgb output nonzero during sync");
            error_count++;
        end

endmodule

bind video_composite_top video_composite_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .next_frame   (next_frame),
    .next_line    (next_line),
    .vblank_pulse (vblank_pulse),
    .luma         (luma),
    .rgb_r        (rgb_r),
    .rgb_g        (rgb_g),
    .rgb_b        (rgb_b),
    .rgb_sync_n   (rgb_sync_n)
);

`default_nettype wire

// File: verification/video_composite_tb.sv
`timescale 1ns/10ps
`default_nettype none

module video_composite_tb;

    localparam int H_SYNC        = 118;
    localparam int H_BACK_PORCH  = 152;
    localparam int H_ACTIVE      = 1280;
    localparam int H_FRONT_PORCH = 38;
    localparam int H_BURST_START = 132;
    localparam int H_BURST_END   = 196;
    localparam int H_TOTAL       = H_SYNC + H_BACK_PORCH + H_ACTIVE + H_FRONT_PORCH;
    localparam int H_HALF        = H_TOTAL / 2;
    localparam int H_ACT_FIRST   = H_SYNC + H_BACK_PORCH;

    // two full frames plus some lines of margin
    localparam int FRAME_CYCLES   = H_TOTAL * 525;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 20 * H_TOTAL;

    localparam int NUM_CASES    = 10;
    localparam int REWRITE_CASE = 3;

    // half-line numbers and pulse widths as plain integers for the model
    localparam int EQ1_END     = int'(video_pkg::V_EQ1_END);
    localparam int SYNC_FIRST  = int'(video_pkg::V_SYNC_FIRST);
    localparam int SYNC_LAST   = int'(video_pkg::V_SYNC_LAST);
    localparam int EQ2_END     = int'(video_pkg::V_EQ2_END);
    localparam int FIELD1_LAST = int'(video_pkg::V_FIELD1_LAST);
    localparam int FRAME_LAST  = int'(video_pkg::V_FRAME_LAST);
    localparam int ACT0_FIRST  = int'(video_pkg::V_ACT0_FIRST);
    localparam int ACT0_LAST   = int'(video_pkg::V_ACT0_LAST);
    localparam int ACT1_FIRST  = int'(video_pkg::V_ACT1_FIRST);
    localparam int ACT1_LAST   = int'(video_pkg::V_ACT1_LAST);
    localparam int VSYNC_LEN   = int'(video_pkg::VSYNC_PULSE_LEN);
    localparam int EQ_LEN      = int'(video_pkg::EQ_PULSE_LEN);

    typedef struct packed {
        logic        sync_n;
        logic [5:0]  luma;
        logic [5:0]  chroma;
        logic [11:0] rgb;
    } expect_t;

    logic                  clk;
    logic                  rst;
    video_pkg::pal_index_t pixel_index;
    logic                  pal_wr;
    video_pkg::pal_index_t pal_addr;
    video_pkg::rgb12_t     pal_data;
    logic                  next_frame, next_line, next_pixel, vblank_pulse, current_field;
    video_pkg::level6_t    luma, chroma;
    video_pkg::color4_t    rgb_r, rgb_g, rgb_b;
    logic                  rgb_sync_n;

    logic [11:0] case_words [3 * NUM_CASES];
    logic [3:0]  case_idx [NUM_CASES];
    logic [11:0] case_rgb [NUM_CASES];
    logic [5:0]  case_luma [NUM_CASES];

    // case number whose color each palette entry holds
    int          model_case [16];
    int          wr_case;
    int          m_hcnt, m_vcnt;
    logic        m_field;
    logic        last_field;
    logic [1:0]  m_phase;
    expect_t     exp_pend, exp_cur;
    int unsigned lcg_state = 89;
    int          cycle_count = 0;
    int          frame_count = 0;
    int          vblank_count = 0;
    int          line_pixels = 0;
    int          rewrite_hits = 0;

    video_composite_top UUT (
        .clk           (clk),
        .rst           (rst),
        .pixel_index   (pixel_index),
        .pal_wr        (pal_wr),
        .pal_addr      (pal_addr),
        .pal_data      (pal_data),
        .next_frame    (next_frame),
        .next_line     (next_line),
        .next_pixel    (next_pixel),
        .vblank_pulse  (vblank_pulse),
        .current_field (current_field),
        .luma          (luma),
        .chroma        (chroma),
        .rgb_r         (rgb_r),
        .rgb_g         (rgb_g),
        .rgb_b         (rgb_b),
        .rgb_sync_n    (rgb_sync_n)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    function int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic v_active_at(int v);
        return (v >= ACT0_FIRST && v <= ACT0_LAST) || (v >= ACT1_FIRST && v <= ACT1_LAST);
    endfunction

    function automatic logic active_at(int h, int v);
        return v_active_at(v) && h >= H_ACT_FIRST && h < H_ACT_FIRST + H_ACTIVE;
    endfunction

    function automatic logic burst_at(int h, int v);
        return v_active_at(v) && h >= H_BURST_START && h < H_BURST_END;
    endfunction

    function automatic logic half_line_end(int h);
        return h == H_HALF - 1 || h == H_TOTAL - 1;
    endfunction

    // pulse shape from the class of the half-line inside its field
    function automatic logic sync_n_at(int h, int v);
        int vrel;
        int hpos;
        vrel = (v > FIELD1_LAST) ? v - FIELD1_LAST - 1 : v;
        hpos = (h >= H_HALF) ? h - H_HALF : h;
        if (vrel >= SYNC_FIRST && vrel <= SYNC_LAST) begin
            return hpos >= VSYNC_LEN;
        end
        if (vrel <= EQ1_END || (vrel > SYNC_LAST && vrel <= EQ2_END)) begin
            return hpos >= EQ_LEN;
        end
        return h >= H_SYNC;
    endfunction

    function automatic expect_t idle_expect();
        expect_t e;
        e.sync_n = 1'b1;
        e.luma   = video_pkg::LUMA_BLANK;
        e.chroma = video_pkg::CHROMA_MID;
        e.rgb    = '0;
        return e;
    endfunction

    // outputs two cycles after counter state h, v with pixel index idx
    function automatic expect_t expect_for(int h, int v, logic [3:0] idx, logic [1:0] ph);
        expect_t     e;
        logic [11:0] rgb;
        int          y4;
        int          u;
        int          vc;
        int          ofs;
        e = idle_expect();
        e.sync_n = sync_n_at(h, v);
        if (!e.sync_n) begin
            e.luma = video_pkg::LUMA_SYNC;
        end
        if (active_at(h, v)) begin
            rgb = case_rgb[model_case[idx]];
            y4  = (5 * int'(rgb[11:8]) + 9 * int'(rgb[7:4]) + 2 * int'(rgb[3:0])) / 16;
            u   = int'(rgb[3:0]) - y4;
            vc  = int'(rgb[11:8]) - y4;
            case (ph)
                2'd0: ofs = u;
                2'd1: ofs = vc;
                2'd2: ofs = -u;
                default: ofs = -vc;
            endcase
            e.luma   = case_luma[model_case[idx]];
            e.chroma = 6'(int'(video_pkg::CHROMA_MID) + ofs);
            e.rgb    = rgb;
        end else if (burst_at(h, v)) begin
            if (ph == 2'd0) begin
                e.chroma = video_pkg::CHROMA_MID + video_pkg::BURST_AMP;
            end else if (ph == 2'd2) begin
                e.chroma = video_pkg::CHROMA_MID - video_pkg::BURST_AMP;
            end
        end
        return e;
    endfunction

    task automatic write_entry(input logic [3:0] idx, input int c);
        @(posedge clk);
        pal_wr   <= 1'b1;
        pal_addr <= idx;
        pal_data <= case_rgb[c];
        wr_case  <= c;
        @(posedge clk);
        pal_wr   <= 1'b0;
    endtask

    // fresh index every cycle so every next_pixel cycle gets one
    always @(posedge clk) begin
        if (!rst) begin
            pixel_index <= case_idx[(lcg_next() >> 16) % NUM_CASES];
        end
    end

    // reference counters with expected outputs queued two deep
    always @(posedge clk) begin
        if (rst) begin
            m_hcnt   <= 0;
            m_vcnt   <= 0;
            m_field  <= 1'b1;
            m_phase  <= 2'd0;
            exp_pend <= idle_expect();
            exp_cur  <= idle_expect();
        end else begin
            exp_cur  <= exp_pend;
            exp_pend <= expect_for(m_hcnt, m_vcnt, pixel_index, m_phase + 2'd1);
            if (active_at(m_hcnt, m_vcnt) && pixel_index == case_idx[0] &&
                model_case[case_idx[0]] == REWRITE_CASE) begin
                rewrite_hits <= rewrite_hits + 1;
            end
            if (pal_wr) begin
                model_case[pal_addr] <= wr_case;
            end
            m_hcnt  <= (m_hcnt == H_TOTAL - 1) ? 0 : m_hcnt + 1;
            m_phase <= m_phase + 2'd1;
            if (half_line_end(m_hcnt)) begin
                m_vcnt <= (m_vcnt == FRAME_LAST) ? 0 : m_vcnt + 1;
                if (m_vcnt == FRAME_LAST) begin
                    m_field <= 1'b1;
                end else if (m_vcnt == FIELD1_LAST) begin
                    m_field <= 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin : check
        logic exp_line;
        logic exp_pixel;
        logic exp_vblank;
        logic exp_frame;
        string where;
        if (!rst) begin
            exp_line   = (m_hcnt == H_ACT_FIRST - 1);
            exp_pixel  = (m_hcnt >= H_ACT_FIRST && m_hcnt < H_ACT_FIRST + H_ACTIVE);
            exp_vblank = half_line_end(m_hcnt) &&
                         (m_vcnt == FIELD1_LAST || m_vcnt == FRAME_LAST);
            exp_frame  = exp_line && (m_vcnt == ACT0_FIRST || m_vcnt == ACT1_FIRST);
            where = $sformatf("(hcnt %0d, vcnt %0d)", m_hcnt, m_vcnt);

            assert (UUT.u_assertions.error_count == 0)
                else report_error("a bound assertion on the DUT outputs failed");
            assert (rgb_sync_n === exp_cur.sync_n)
                else report_error($sformatf("rgb_sync_n %b, expected %b %s",
                    rgb_sync_n, exp_cur.sync_n, where));
            assert (luma === exp_cur.luma)
                else report_error($sformatf("luma %0d, expected %0d %s",
                    luma, exp_cur.luma, where));
            assert (chroma === exp_cur.chroma)
                else report_error($sformatf("chroma %0d, expected %0d %s",
                    chroma, exp_cur.chroma, where));
            assert ({rgb_r, rgb_g, rgb_b} === exp_cur.rgb)
                else report_error($sformatf("rgb %h, expected %h %s",
                    {rgb_r, rgb_g, rgb_b}, exp_cur.rgb, where));
            assert (next_line === exp_line)
                else report_error($sformatf("next_line %b, expected %b %s",
                    next_line, exp_line, where));
            assert (next_pixel === exp_pixel)
                else report_error($sformatf("next_pixel %b, expected %b %s",
                    next_pixel, exp_pixel, where));
            assert (vblank_pulse === exp_vblank)
                else report_error($sformatf("vblank_pulse %b, expected %b %s",
                    vblank_pulse, exp_vblank, where));
            assert (next_frame === exp_frame)
                else report_error($sformatf("next_frame %b, expected %b %s",
                    next_frame, exp_frame, where));

            if (next_frame) begin
                assert (current_field === m_field)
                    else report_error($sformatf("current_field %b, expected %b %s",
                        current_field, m_field, where));
                if (frame_count > 0) begin
                    assert (current_field !== last_field)
                        else report_error($sformatf("current_field %b did not alternate %s",
                            current_field, where));
                end
                last_field = current_field;
                frame_count++;
            end
            if (vblank_pulse) begin
                vblank_count++;
            end
            if (next_pixel) begin
                line_pixels++;
            end
            if (m_hcnt == H_TOTAL - 1) begin
                assert (line_pixels == H_ACTIVE)
                    else report_error($sformatf("%0d next_pixel cycles in line, expected %0d %s",
                        line_pixels, H_ACTIVE, where));
                line_pixels = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the two frames did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial begin
        rst         = 1'b1;
        pixel_index = '0;
        pal_wr      = 1'b0;
        pal_addr    = '0;
        pal_data    = '0;
        wr_case     = 0;
        // case 0 is black, matching the cleared palette
        for (int i = 0; i < 16; i++) begin
            model_case[i] = 0;
        end
        $readmemh("verification/video_cases.txt", case_words);
        for (int i = 0; i < NUM_CASES; i++) begin
            case_idx[i]  = case_words[3 * i][3:0];
            case_rgb[i]  = case_words[3 * i + 1];
            case_luma[i] = case_words[3 * i + 2][5:0];
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // palette load lands in the vertical blanking of field 0
        for (int i = 0; i < NUM_CASES; i++) begin
            write_entry(case_idx[i], i);
        end

        // recolor one entry a hundred lines into the first field
        do @(posedge clk); while (next_frame !== 1'b1);
        repeat (100) begin
            do @(posedge clk); while (next_line !== 1'b1);
        end
        write_entry(case_idx[0], REWRITE_CASE);

        while (vblank_count < 4) @(posedge clk);
        repeat (4) @(posedge clk);

        if (frame_count == 4 && vblank_count == 4 && rewrite_hits > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            assert (frame_count == 4)
                else report_error($sformatf("%0d next_frame strobes, expected 4", frame_count));
            assert (vblank_count == 4)
                else report_error($sformatf("%0d vblank pulses, expected 4", vblank_count));
            report_error("the rewritten palette entry never reached an active pixel");
        end
    end

endmodule

`default_nettype wire
